//--- hdl/memHandler_consts.svh
`ifndef MEMHANDLER_CONSTS_SVH
`define MEMHANDLER_CONSTS_SVH

// Address and data word width of the CPU
`define DATA_W 32

// Width of the memOp code from the control unit
`define MEMOP_W 4

// Cycle budget for one fetch plus one data access
`define ACCESS_TIMEOUT 64

`endif

//--- hdl/memOpPkg.sv
`include "memHandler_consts.svh"

package memOpPkg;

    typedef enum logic [`MEMOP_W-1:0] {
        opNone = 0,         // No memory operation
        opLb   = 1,         // Load byte, sign extended
        opLh   = 2,         // Load halfword, sign extended
        opLw   = 3,         // Load word
        opLbu  = 4,         // Load byte, zero extended
        opLhu  = 5,         // Load halfword, zero extended
        opSb   = 6,         // Store low byte
        opSh   = 7,         // Store low halfword
        opSw   = 8          // Store word
    } memOpT;

    typedef enum logic [1:0] {
        rwiIdle  = 2'd0,    // No data transfer
        rwiWrite = 2'd1,    // Store to memory
        rwiRead  = 2'd2     // Load from memory
    } rwiT;

endpackage

//--- hdl/handlerPkg.sv
package handlerPkg;

    typedef enum logic [1:0] {
        stFetch     = 2'd0,     // Issue the instruction fetch
        stFetchWait = 2'd1,     // Fetch open on the bus
        stData      = 2'd2,     // Instruction valid, optional data start
        stDataWait  = 2'd3      // Load or store open on the bus
    } handlerStateT;

    typedef enum logic [1:0] {
        brIdle    = 2'd0,       // Waiting for xferStart
        brReq     = 2'd1,       // memReq high, waiting for memAck
        brRelease = 2'd2,       // memReq dropped, waiting for memAck low
        brDone    = 2'd3        // One cycle end of transfer
    } bridgeStateT;

endpackage

//--- hdl/loadStoreFormat.sv
`timescale 1ns/1ps
`include "memHandler_consts.svh"

module loadStoreFormat (
    input  memOpPkg::memOpT     memOp,      // Operation code from the control unit
    input  logic [`DATA_W-1:0]  storeSrc,   // Selected register or FPU word
    input  logic [`DATA_W-1:0]  rdWord,     // Raw word read from memory
    output logic [`DATA_W-1:0]  wrWord,     // Word sent to memory on a store
    output logic [`DATA_W-1:0]  loadWord    // Extended word for the register file
);
    import memOpPkg::*;

    // Store side
    always_comb begin
        case (memOp)
            opSb: begin
                wrWord = {24'b0, storeSrc[7:0]};            // Low byte, upper bits cleared
            end
            opSh: begin
                wrWord = {16'b0, storeSrc[15:0]};           // Low halfword
            end
            opSw: begin
                wrWord = storeSrc;                          // Full word as is
            end
            default: begin
                wrWord = '0;                                // Loads and opNone write nothing
            end
        endcase
    end

    // Load side
    always_comb begin
        case (memOp)
            opLb: begin
                loadWord = {{24{rdWord[7]}}, rdWord[7:0]};      // Sign extend byte
            end
            opLh: begin
                loadWord = {{16{rdWord[15]}}, rdWord[15:0]};    // Sign extend halfword
            end
            opLw: begin
                loadWord = rdWord;
            end
            opLbu: begin
                loadWord = {24'b0, rdWord[7:0]};                // Zero extend byte
            end
            opLhu: begin
                loadWord = {16'b0, rdWord[15:0]};               // Zero extend halfword
            end
            default: begin
                loadWord = '0;                                  // Stores return nothing
            end
        endcase
    end

endmodule

//--- hdl/busBridge.sv
`timescale 1ns/1ps
`include "memHandler_consts.svh"

module busBridge (
    input  logic                clk,
    input  logic                nrst,
    input  logic                xferStart,      // One cycle request from the handler
    input  logic                xferWe,         // Write when high
    input  logic [`DATA_W-1:0]  xferAddr,
    input  logic [`DATA_W-1:0]  xferWrData,
    input  logic                memAck,         // Memory side acknowledge
    input  logic [`DATA_W-1:0]  memRdData,      // Valid while memAck is high
    output logic                memReq,
    output logic                memWe,
    output logic [`DATA_W-1:0]  memAddr,
    output logic [`DATA_W-1:0]  memWrData,
    output logic [`DATA_W-1:0]  xferRdData,     // Word captured at ack
    output logic                xferDone        // End of transfer pulse
);
    import handlerPkg::*;

    bridgeStateT state;
    bridgeStateT stateNext;

    // Four phase walk
    always_comb begin
        stateNext = state;
        case (state)
            brIdle:    if (xferStart) stateNext = brReq;
            brReq:     if (memAck)    stateNext = brRelease;    // Release req once ack is seen
            brRelease: if (!memAck)   stateNext = brDone;       // Memory finished its half
            default:                  stateNext = brIdle;       // brDone lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= brIdle;
            memWe <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == brIdle && xferStart) begin
                memWe <= xferWe;                    // Held for the whole handshake
            end else if (state == brDone) begin
                memWe <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == brIdle && xferStart) begin
            memAddr   <= xferAddr;                  // Stable while memReq is high
            memWrData <= xferWrData;
        end
        if (state == brReq && memAck) begin
            xferRdData <= memRdData;                // Capture before req drops
        end
    end

    assign memReq   = (state == brReq);             // Rises the cycle after xferStart
    assign xferDone = (state == brDone);

    // Memory raises ack only in answer to a request
    assert property (@(posedge clk) disable iff (!nrst)
        $rose(memAck) |-> memReq);

    // Handler only starts a transfer on an idle bridge
    assert property (@(posedge clk) disable iff (!nrst)
        xferStart |-> (state == brIdle));

endmodule

//--- hdl/memHandler.sv
`timescale 1ns/1ps
`include "memHandler_consts.svh"

module memHandler (
    input  logic                clk,
    input  logic                nrst,
    input  logic                memRead,        // Current instruction loads
    input  logic                memWrite,       // Current instruction stores
    input  logic                memSource,      // Store from the FPU when high
    input  logic                xferDone,
    input  memOpPkg::memOpT     memOp,
    input  logic [`DATA_W-1:0]  pc,
    input  logic [`DATA_W-1:0]  aluAddress,     // Load/store address from the ALU
    input  logic [`DATA_W-1:0]  fpuData,
    input  logic [`DATA_W-1:0]  regData,
    input  logic [`DATA_W-1:0]  xferRdData,
    input  logic [`DATA_W-1:0]  loadWord,       // Extended word from the formatter
    output logic                xferStart,
    output logic                xferWe,
    output logic                freeze,         // Stalls the CPU while a transfer is open
    output logic                instrValid,
    output logic                accessDone,
    output logic [`DATA_W-1:0]  xferAddr,
    output logic [`DATA_W-1:0]  storeSrc,
    output logic [`DATA_W-1:0]  rdWord,
    output logic [`DATA_W-1:0]  instr,
    output logic [`DATA_W-1:0]  dataToCpu
);
    import memOpPkg::*;
    import handlerPkg::*;

    handlerStateT state;
    handlerStateT stateNext;
    rwiT          rwi;              // Access kind of the current instruction
    logic         fetchGo;          // Fetch armed for this cycle
    logic         fetchGoNext;
    logic         dataStart;
    logic         dataDoneQ;        // Data transfer finished last cycle
    logic         fetchPhase;

    always_comb begin
        if (memWrite) begin
            rwi = rwiWrite;
        end else if (memRead) begin
            rwi = rwiRead;
        end else begin
            rwi = rwiIdle;
        end
    end

    assign fetchPhase = (state == stFetch) || (state == stFetchWait);
    assign dataStart  = (state == stData) && (rwi != rwiIdle);    // Same cycle as instrValid
    assign xferStart  = ((state == stFetch) && fetchGo) || dataStart;
    assign xferWe     = dataStart && (rwi == rwiWrite);
    assign xferAddr   = fetchPhase ? pc : aluAddress;             // Address mux
    assign storeSrc   = memSource ? fpuData : regData;
    assign rdWord     = xferRdData;
    assign freeze     = xferStart || (state == stFetchWait) || (state == stDataWait);
    assign instrValid = (state == stData);                        // stData lasts one cycle
    assign accessDone = ((state == stData) && !dataStart) || dataDoneQ;

    always_comb begin
        stateNext   = state;
        fetchGoNext = 1'b0;
        case (state)
            stFetch: begin
                if (fetchGo) begin
                    stateNext = stFetchWait;
                end else begin
                    fetchGoNext = 1'b1;     // Idle cycle after reset or accessDone
                end
            end
            stFetchWait: if (xferDone) stateNext = stData;
            stData: begin
                stateNext   = dataStart ? stDataWait : stFetch;
                fetchGoNext = !dataStart;   // No data access, next fetch follows accessDone
            end
            default: if (xferDone) stateNext = stFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= stFetch;
            fetchGo   <= 1'b0;
            dataDoneQ <= 1'b0;
        end else begin
            state     <= stateNext;
            fetchGo   <= fetchGoNext;
            dataDoneQ <= (state == stDataWait) && xferDone;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetchWait && xferDone) begin
            instr <= xferRdData;            // Fetched instruction word
        end
        if (state == stDataWait && xferDone && rwi == rwiRead) begin
            dataToCpu <= loadWord;
        end
    end

    // Control unit decodes one access kind per instruction
    assert property (@(posedge clk) disable iff (!nrst)
        (state == stData || state == stDataWait) |-> !(memRead && memWrite));

    // Store must reach the formatter with a store code
    assert property (@(posedge clk) disable iff (!nrst)
        (dataStart && rwi == rwiWrite) |-> (memOp inside {opSb, opSh, opSw}));

endmodule

//--- hdl/memSubsystem.sv
`timescale 1ns/1ps
`include "memHandler_consts.svh"

module memSubsystem (
    input  logic                clk,
    input  logic                nrst,
    input  logic [`DATA_W-1:0]  pc,
    input  logic                memRead,
    input  logic                memWrite,
    input  logic                memSource,
    input  memOpPkg::memOpT     memOp,
    input  logic [`DATA_W-1:0]  aluAddress,
    input  logic [`DATA_W-1:0]  fpuData,
    input  logic [`DATA_W-1:0]  regData,
    output logic [`DATA_W-1:0]  instr,
    output logic                instrValid,
    output logic [`DATA_W-1:0]  dataToCpu,
    output logic                accessDone,
    output logic                freeze,
    output logic                memReq,         // Four phase request to memory
    output logic [`DATA_W-1:0]  memAddr,
    output logic                memWe,
    output logic [`DATA_W-1:0]  memWrData,
    input  logic                memAck,
    input  logic [`DATA_W-1:0]  memRdData
);
    logic               xferStart, xferWe, xferDone;
    logic [`DATA_W-1:0] xferAddr, xferRdData;
    logic [`DATA_W-1:0] storeSrc, rdWord, wrWord, loadWord;     // Formatter in and out

    memHandler handler0 (.clk, .nrst, .memRead, .memWrite, .memSource, .xferDone, .memOp,
        .pc, .aluAddress, .fpuData, .regData, .xferRdData, .loadWord, .xferStart,
        .xferWe, .freeze, .instrValid, .accessDone, .xferAddr, .storeSrc, .rdWord,
        .instr, .dataToCpu);

    // Same memOp drives store formatting and load extension
    loadStoreFormat format0 (.memOp, .storeSrc, .rdWord, .wrWord, .loadWord);

    busBridge bridge0 (
        .clk, .nrst, .xferStart, .xferWe, .xferAddr,
        .xferWrData (wrWord),                   // Formatted store word
        .memAck, .memRdData, .memReq, .memWe, .memAddr, .memWrData,
        .xferRdData, .xferDone
    );

endmodule

//--- sim/extMemModel.sv
`timescale 1ns/1ps
`include "memHandler_consts.svh"

module extMemModel (
    input  logic                clk,
    input  logic                nrst,
    input  logic                memReq,
    input  logic                memWe,
    input  logic [`DATA_W-1:0]  memAddr,
    input  logic [`DATA_W-1:0]  memWrData,
    input  logic [`DATA_W-1:0]  instAddr,       // Location holding the instruction
    input  logic [`DATA_W-1:0]  instWord,
    input  logic [`DATA_W-1:0]  dataAddr,       // Location holding the load word
    input  logic [`DATA_W-1:0]  dataWord,
    output logic                memAck,
    output logic [`DATA_W-1:0]  memRdData,      // Valid while memAck is high
    output logic [`DATA_W-1:0]  lastWrAddr,     // Write capture
    output logic [`DATA_W-1:0]  lastWrData,
    output int                  wrCount
);
    integer seed = 32'h6a92_4126;
    int     delayLeft;
    logic   waiting;                            // Delay drawn, ack pending

    function automatic logic [`DATA_W-1:0] readWord(input logic [`DATA_W-1:0] addr);
        if (addr == instAddr) begin
            return instWord;
        end else if (addr == dataAddr) begin
            return dataWord;
        end
        return addr ^ 32'ha5c3_5a3c;            // Fill for unloaded locations
    endfunction

    always @(posedge clk) begin
        if (!nrst) begin
            memAck     <= 1'b0;
            memRdData  <= '0;
            lastWrAddr <= '0;
            lastWrData <= '0;
            wrCount    <= 0;
            delayLeft  <= 0;
            waiting    <= 1'b0;
        end else if (memAck) begin
            if (!memReq) begin
                memAck <= 1'b0;                 // Fourth phase, req already released
            end
        end else if (memReq) begin
            if (!waiting) begin
                waiting   <= 1'b1;
                delayLeft <= $unsigned($random(seed)) % 4;      // 0 to 3 extra cycles
            end else if (delayLeft == 0) begin
                waiting   <= 1'b0;
                memAck    <= 1'b1;
                memRdData <= readWord(memAddr);
                if (memWe) begin
                    lastWrAddr <= memAddr;
                    lastWrData <= memWrData;
                    wrCount    <= wrCount + 1;
                end
            end else begin
                delayLeft <= delayLeft - 1;
            end
        end
    end

endmodule

//--- sim/memSubsystem_tb.sv
`timescale 1ns/1ps
`include "memHandler_consts.svh"

module memSubsystem_tb;
    import memOpPkg::*;

    localparam int numFields   = 12;            // Hex words per pattern line
    localparam int maxLines    = 32;
    localparam int resetCycles = 3;

    logic               clk = 1'b0;
    logic               nrst;
    logic               memRead, memWrite, memSource;
    memOpT              memOp;
    logic [`DATA_W-1:0] pc, aluAddress, fpuData, regData;
    logic [`DATA_W-1:0] instr, dataToCpu;
    logic               instrValid, accessDone, freeze;
    logic               memReq, memWe, memAck;
    logic [`DATA_W-1:0] memAddr, memWrData, memRdData;
    logic [`DATA_W-1:0] instAddr, instWord, dataAddr, dataWord;    // Model contents per line
    logic [`DATA_W-1:0] lastWrAddr, lastWrData;
    int                 wrCount;
    logic [`DATA_W-1:0] patterns [0:maxLines*numFields-1];
    int                 lineCount = 0;
    int                 errors = 0;
    int                 failedTests = 0;
    int                 cycles = 0;
    int                 reqCount = 0;           // Bus requests seen in the current line
    int                 wrBase = 0;             // Model write count before the line
    logic               reqPrev = 1'b0;
    logic [`DATA_W-1:0] fetchAddrSeen, dataAddrSeen;
    logic               dataWeSeen;

    memSubsystem dut0 (.clk, .nrst, .pc, .memRead, .memWrite, .memSource, .memOp, .aluAddress,
        .fpuData, .regData, .instr, .instrValid, .dataToCpu, .accessDone, .freeze, .memReq,
        .memAddr, .memWe, .memWrData, .memAck, .memRdData);

    extMemModel mem0 (.clk, .nrst, .memReq, .memWe, .memAddr, .memWrData, .instAddr, .instWord,
        .dataAddr, .dataWord, .memAck, .memRdData, .lastWrAddr, .lastWrData, .wrCount);

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("At %0d ns: %s", $time, what);
        end
    endtask

    // Bus monitor where the first request of a line is the fetch
    always @(negedge clk) begin
        if (nrst) begin
            if (memReq && !reqPrev) begin
                if (reqCount == 0) begin
                    fetchAddrSeen = memAddr;
                end else begin
                    dataAddrSeen = memAddr;
                    dataWeSeen   = memWe;
                end
                reqCount++;
            end
            checkTrue(freeze || !(memReq || memAck),
                "freeze is low while a bus transfer is open");
        end
        reqPrev = memReq;
    end

    task automatic setupLine(input int n);
        int base;
        base       = n * numFields;
        pc         = patterns[base];
        instAddr   = patterns[base];
        instWord   = patterns[base + 1];
        dataAddr   = patterns[base + 6];
        dataWord   = patterns[base + 9];
        memRead    = 1'b0;                      // Idle until instrValid
        memWrite   = 1'b0;
        memSource  = 1'b0;
        memOp      = opNone;
        aluAddress = '0;
        reqCount   = 0;
    endtask

    task automatic runLine(input int n);
        int   base;
        int   errorsBefore;
        logic isLoad;
        logic isStore;
        base         = n * numFields;
        errorsBefore = errors;
        isLoad       = patterns[base + 2][0];
        isStore      = patterns[base + 3][0];
        wrBase       = wrCount;
        do begin
            @(posedge clk);
            #1;
        end while (!instrValid);
        checkValue("instr", instr, patterns[base + 1]);
        checkValue("memAddr (fetch)", fetchAddrSeen, patterns[base]);
        memRead    = isLoad;                    // Held until accessDone
        memWrite   = isStore;
        memSource  = patterns[base + 4][0];
        memOp      = memOpT'(patterns[base + 5][`MEMOP_W-1:0]);
        aluAddress = patterns[base + 6];
        fpuData    = patterns[base + 7];
        regData    = patterns[base + 8];
        do begin
            @(negedge clk);
        end while (!accessDone);
        checkTrue(instrValid == !(isLoad || isStore), "accessDone and instrValid out of step");
        checkTrue(reqCount == ((isLoad || isStore) ? 2 : 1), "wrong number of bus requests");
        if (isLoad || isStore) begin
            checkValue("memAddr (data)", dataAddrSeen, patterns[base + 6]);
            checkTrue(dataWeSeen == isStore, "memWe does not match the access kind");
        end
        if (isLoad) begin
            checkValue("dataToCpu", dataToCpu, patterns[base + 10]);
        end
        checkTrue(wrCount == wrBase + (isStore ? 1 : 0), "memory write count is wrong");
        if (isStore) begin
            checkValue("mem0.lastWrAddr", lastWrAddr, patterns[base + 6]);
            checkValue("mem0.lastWrData", lastWrData, patterns[base + 11]);
        end
        if (errors != errorsBefore) begin
            failedTests++;
        end
        $display("Test %0d %s at pc %h: %s", n, memOp.name(), pc,
            (errors == errorsBefore) ? "pass" : "fail");
    endtask

    initial begin
        nrst    = 1'b0;
        fpuData = '0;
        regData = '0;
        for (int i = 0; i < maxLines * numFields; i++) begin
            patterns[i] = '1;                   // End marker in the pc column
        end
        $readmemh("sim/memPatterns.txt", patterns);
        while (lineCount < maxLines && patterns[lineCount * numFields] !== '1) begin
            lineCount++;
        end
        checkTrue(lineCount > 0, "no pattern lines read from sim/memPatterns.txt");
        setupLine(0);
        repeat (resetCycles) @(posedge clk);
        #1;
        nrst = 1'b1;
        @(negedge clk);
        checkTrue(!memReq && !freeze && !instrValid && !accessDone,
            "outputs not idle after reset");
        if (errors != 0) begin
            failedTests++;
        end
        $display("Reset check: %s", (errors == 0) ? "pass" : "fail");
        for (int n = 0; n < lineCount; n++) begin
            if (n > 0) begin
                @(posedge clk);
                #1;
                setupLine(n);                   // Next fetch starts after accessDone
            end
            runLine(n);
        end
        $display("Summary: %0d tests, %0d failed, %0d error(s)", lineCount + 1, failedTests,
            errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog with a budget per pattern line plus reset
    initial begin
        int limit;
        @(posedge clk);
        limit = `ACCESS_TIMEOUT * lineCount + resetCycles + 4;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT did not finish its accesses", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- project.f
+incdir+hdl
hdl/memOpPkg.sv
hdl/handlerPkg.sv
hdl/loadStoreFormat.sv
hdl/busBridge.sv
hdl/memHandler.sv
hdl/memSubsystem.sv
sim/extMemModel.sv
sim/memSubsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memSubsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module memSubsystem_tb -f project.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

//--- sim/memPatterns.txt
// pc instr memRead memWrite memSource memOp aluAddress fpuData regData memWord expData expWrite
// memOp: 0 none, 1 lb, 2 lh, 3 lw, 4 lbu, 5 lhu, 6 sb, 7 sh, 8 sw
00000100 00000013 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00000000
00000104 00802083 1 0 0 1 00002000 00000000 00000000 123456f0 fffffff0 00000000
00000108 00902103 1 0 0 1 00002004 00000000 00000000 abcdef7f 0000007f 00000000
0000010c 00a11183 1 0 0 2 00002008 00000000 00000000 00128001 ffff8001 00000000
00000110 00b11203 1 0 0 2 0000200c 00000000 00000000 ffff7ffe 00007ffe 00000000
00000114 00c12283 1 0 0 3 00002010 00000000 00000000 deadbeef deadbeef 00000000
00000118 00d14303 1 0 0 4 00002014 00000000 00000000 5555aa80 00000080 00000000
0000011c 00e15383 1 0 0 5 00002018 00000000 00000000 1234c3a5 0000c3a5 00000000
00000120 00112023 0 1 0 6 00003000 11111111 cafeba12 00000000 00000000 00000012
00000124 00212227 0 1 1 6 00003004 876543c9 00000000 00000000 00000000 000000c9
00000128 00311423 0 1 0 7 00003008 ffffffff 13579bdf 00000000 00000000 00009bdf
0000012c 00411627 0 1 1 7 0000300c 2468ace0 99999999 00000000 00000000 0000ace0
00000130 00512823 0 1 0 8 00003010 00000000 89abcdef 00000000 00000000 89abcdef
00000134 00612a27 0 1 1 8 00003014 3f800000 12345678 00000000 00000000 3f800000
00000138 00000033 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00000000
0000013c 00f12b83 1 0 0 3 00002020 00000000 00000000 0f0f0f0f 0f0f0f0f 00000000
